// ==== compile.f ====
hdl/mem_pkg.sv
hdl/mem_access_fsm.sv
hdl/lsu_align.sv
hdl/bus_router.sv
hdl/clint_timer.sv
hdl/mem_stage.sv
tests/tb_mem_stage.sv

// ==== hdl/bus_router.sv ====
`default_nettype none

module bus_router #(
    parameter logic [63:0] CLINT_BASE = 64'h0200_0000
) (
    input  wire logic               up_valid_i,
    input  wire logic [63:0]        up_addr_i,
    input  wire logic [63:0]        up_wdata_i,
    input  wire mem_pkg::mem_size_e up_size_i,
    input  wire logic               up_write_i,
    output logic                    up_ready_o,
    output logic [63:0]             up_rdata_o,
    output mem_pkg::mem_resp_e      up_resp_o,

    output logic                    mem_valid_o,
    input  wire logic               mem_ready_i,
    input  wire logic [63:0]        mem_rdata_i,
    output logic [63:0]             mem_wdata_o,
    output logic [63:0]             mem_addr_o,
    output mem_pkg::mem_size_e      mem_size_o,
    output logic                    mem_write_o,
    input  wire mem_pkg::mem_resp_e mem_resp_i,

    output logic                    clint_valid_o,
    input  wire logic               clint_ready_i,
    input  wire logic [63:0]        clint_rdata_i,
    output logic [63:0]             clint_wdata_o,
    output logic [63:0]             clint_addr_o,
    output mem_pkg::mem_size_e      clint_size_o,
    output logic                    clint_write_o,
    input  wire mem_pkg::mem_resp_e clint_resp_i
);

    localparam logic [63:0] CLINT_END = CLINT_BASE + {32'd0, mem_pkg::CLINT_SPAN};

    logic sel_clint;

    assign sel_clint = (up_addr_i >= CLINT_BASE) && (up_addr_i < CLINT_END);

    // payload goes to both sides, valid picks the target.
    assign mem_valid_o   = up_valid_i & ~sel_clint;
    assign mem_addr_o    = up_addr_i;
    assign mem_wdata_o   = up_wdata_i;
    assign mem_size_o    = up_size_i;
    assign mem_write_o   = up_write_i;

    assign clint_valid_o = up_valid_i & sel_clint;
    assign clint_addr_o  = up_addr_i;
    assign clint_wdata_o = up_wdata_i;
    assign clint_size_o  = up_size_i;
    assign clint_write_o = up_write_i;

    assign up_ready_o = sel_clint ? clint_ready_i : mem_ready_i;
    assign up_rdata_o = sel_clint ? clint_rdata_i : mem_rdata_i;
    assign up_resp_o  = sel_clint ? clint_resp_i : mem_resp_i;

endmodule

`default_nettype wire

// ==== hdl/clint_timer.sv ====
`default_nettype none

module clint_timer #(
    parameter logic [63:0] CLINT_BASE = 64'h0200_0000,
    parameter int unsigned TICK_DIV   = 4
) (
    input  wire logic               clk,
    input  wire logic               rst_n_i,

    input  wire logic               valid_i,
    input  wire logic [63:0]        addr_i,
    input  wire logic [63:0]        wdata_i,
    input  wire mem_pkg::mem_size_e size_i,
    input  wire logic               write_i,
    output logic                    ready_o,
    output logic [63:0]             rdata_o,
    output mem_pkg::mem_resp_e      resp_o,

    output logic                    mtip_o
);

    localparam int unsigned DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    logic [63:0]      mtime;
    logic [63:0]      mtimecmp;
    logic [63:0]      rel_addr;
    logic             hit_mtime;
    logic             hit_cmp;
    logic             wr_en;

    assign tick = (div_cnt == DIV_W'(TICK_DIV - 1));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
        end
    end

    // decode inside the 64 KiB window, doubleword only.
    assign rel_addr  = addr_i - CLINT_BASE;
    assign hit_mtime = (rel_addr[63:16] == '0) && (rel_addr[15:0] == mem_pkg::MTIME_OFFSET) &&
                       (size_i == mem_pkg::DWORD);
    assign hit_cmp   = (rel_addr[63:16] == '0) && (rel_addr[15:0] == mem_pkg::MTIMECMP_OFFSET) &&
                       (size_i == mem_pkg::DWORD);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ready_o <= 1'b0;
        end else begin
            ready_o <= valid_i & ~ready_o; // one-cycle pulse after valid.
        end
    end

    assign wr_en = valid_i & ready_o & write_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mtime    <= '0;
            mtimecmp <= '1;
        end else begin
            if (wr_en && hit_mtime) begin
                mtime <= wdata_i; // overrides this cycle's tick.
            end else if (tick) begin
                mtime <= mtime + 64'd1;
            end
            if (wr_en && hit_cmp) begin
                mtimecmp <= wdata_i;
            end
        end
    end

    assign rdata_o = hit_mtime ? mtime : (hit_cmp ? mtimecmp : 64'd0);
    assign resp_o  = (hit_mtime || hit_cmp) ? mem_pkg::OKAY : mem_pkg::ERR;
    assign mtip_o  = (mtime >= mtimecmp);

endmodule

`default_nettype wire

// ==== hdl/lsu_align.sv ====
`default_nettype none

module lsu_align (
    input  wire logic                 mem_read_i,
    input  wire logic                 mem_write_i,
    input  wire mem_pkg::load_type_e  load_type_i,
    input  wire mem_pkg::store_type_e store_type_i,
    input  wire logic [63:0]          ex_result_i,
    input  wire logic [63:0]          wdata_i,
    input  wire logic [63:0]          raw_rdata_i,

    output logic [63:0]               bus_addr_o,
    output logic [63:0]               bus_wdata_o,
    output mem_pkg::mem_size_e        bus_size_o,
    output logic                      bus_write_o,
    output logic [63:0]               rd_data_o
);

    logic [5:0]  lane_shift;
    logic [63:0] rd_shifted;
    logic [63:0] rd_ext;

    assign lane_shift  = {ex_result_i[2:0], 3'b000}; // byte offset in bits.
    assign bus_addr_o  = {ex_result_i[63:3], 3'b000};
    assign bus_wdata_o = wdata_i << lane_shift;
    assign bus_write_o = mem_write_i;

    always_comb begin
        bus_size_o = mem_pkg::DWORD;
        if (mem_write_i) begin
            case (store_type_i)
                mem_pkg::SB: bus_size_o = mem_pkg::BYTE;
                mem_pkg::SH: bus_size_o = mem_pkg::HALF;
                mem_pkg::SW: bus_size_o = mem_pkg::WORD;
                default:     bus_size_o = mem_pkg::DWORD;
            endcase
        end else begin
            case (load_type_i)
                mem_pkg::LB,
                mem_pkg::LBU: bus_size_o = mem_pkg::BYTE;
                mem_pkg::LH,
                mem_pkg::LHU: bus_size_o = mem_pkg::HALF;
                mem_pkg::LW,
                mem_pkg::LWU: bus_size_o = mem_pkg::WORD;
                default:      bus_size_o = mem_pkg::DWORD;
            endcase
        end
    end

    // bring the addressed bytes down to bit 0.
    assign rd_shifted = raw_rdata_i >> lane_shift;

    always_comb begin
        case (load_type_i)
            mem_pkg::LB:  rd_ext = {{56{rd_shifted[7]}}, rd_shifted[7:0]};
            mem_pkg::LH:  rd_ext = {{48{rd_shifted[15]}}, rd_shifted[15:0]};
            mem_pkg::LW:  rd_ext = {{32{rd_shifted[31]}}, rd_shifted[31:0]};
            mem_pkg::LBU: rd_ext = {56'd0, rd_shifted[7:0]};
            mem_pkg::LHU: rd_ext = {48'd0, rd_shifted[15:0]};
            mem_pkg::LWU: rd_ext = {32'd0, rd_shifted[31:0]};
            default:      rd_ext = rd_shifted;
        endcase
    end

    assign rd_data_o = mem_read_i ? rd_ext : ex_result_i; // alu result otherwise.

endmodule

`default_nettype wire

// ==== hdl/mem_access_fsm.sv ====
`default_nettype none

module mem_access_fsm (
    input  wire logic               clk,
    input  wire logic               rst_n_i,

    input  wire logic               inst_valid_i,
    input  wire logic               mem_read_i,
    input  wire logic               mem_write_i,

    input  wire logic               bus_ready_i,
    input  wire logic [63:0]        bus_rdata_i,
    input  wire mem_pkg::mem_resp_e bus_resp_i,
    output logic                    bus_valid_o,

    output logic [63:0]             raw_rdata_o,
    output logic                    access_ok_o,
    output logic                    access_err_o
);

    mem_pkg::access_state_e state_q;
    mem_pkg::access_state_e state_d;
    mem_pkg::mem_resp_e     resp_q;
    logic [63:0]            rdata_q;
    logic                   is_mem;

    assign is_mem = mem_read_i | mem_write_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_pkg::IDLE: begin
                if (inst_valid_i && is_mem) begin
                    state_d = mem_pkg::BUSY;
                end
            end
            mem_pkg::BUSY: begin
                if (bus_ready_i) begin
                    state_d = mem_pkg::DONE;
                end
            end
            mem_pkg::DONE: state_d = mem_pkg::IDLE; // one-cycle completion.
            default:       state_d = mem_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= mem_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // response is sampled on the ready pulse only.
    always_ff @(posedge clk) begin
        if (state_q == mem_pkg::BUSY && bus_ready_i) begin
            rdata_q <= bus_rdata_i;
            resp_q  <= bus_resp_i;
        end
    end

    assign bus_valid_o  = (state_q == mem_pkg::BUSY);
    assign raw_rdata_o  = rdata_q;

    // non-memory ops finish straight out of idle.
    assign access_ok_o  = (state_q == mem_pkg::IDLE && inst_valid_i && !is_mem) ||
                          (state_q == mem_pkg::DONE);
    assign access_err_o = (state_q == mem_pkg::DONE) && (resp_q != mem_pkg::OKAY);

endmodule

`default_nettype wire

// ==== hdl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // access FSM.
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        BUSY = 2'd1,
        DONE = 2'd2
    } access_state_e;

    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LD  = 3'd3,
        LBU = 3'd4,
        LHU = 3'd5,
        LWU = 3'd6
    } load_type_e;

    typedef enum logic [1:0] {
        SB = 2'd0,
        SH = 2'd1,
        SW = 2'd2,
        SD = 2'd3
    } store_type_e;

    // bytes per access is 1 << size.
    typedef enum logic [1:0] {
        BYTE  = 2'd0,
        HALF  = 2'd1,
        WORD  = 2'd2,
        DWORD = 2'd3
    } mem_size_e;

    typedef enum logic [1:0] {
        OKAY = 2'd0,
        ERR  = 2'd2
    } mem_resp_e;

    // core-local timer register map, relative to its base.
    localparam logic [15:0] MTIMECMP_OFFSET = 16'h4000;
    localparam logic [15:0] MTIME_OFFSET    = 16'hBFF8;
    localparam logic [31:0] CLINT_SPAN      = 32'h0001_0000;

endpackage

`default_nettype wire

// ==== hdl/mem_stage.sv ====
`default_nettype none

module mem_stage #(
    parameter logic [63:0] CLINT_BASE = 64'h0200_0000,
    parameter int unsigned TICK_DIV   = 4
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n_i,

    input  wire logic                 inst_valid_i,
    input  wire logic                 mem_read_i,
    input  wire logic                 mem_write_i,
    input  wire mem_pkg::load_type_e  load_type_i,
    input  wire mem_pkg::store_type_e store_type_i,
    input  wire logic [63:0]          ex_result_i,
    input  wire logic [63:0]          wdata_i,
    output logic                      access_ok_o,
    output logic                      access_err_o,
    output logic [63:0]               rd_data_o,

    output logic                      mem_valid_o,
    input  wire logic                 mem_ready_i,
    input  wire logic [63:0]          mem_rdata_i,
    output logic [63:0]               mem_wdata_o,
    output logic [63:0]               mem_addr_o,
    output mem_pkg::mem_size_e        mem_size_o,
    output logic                      mem_write_o,
    input  wire mem_pkg::mem_resp_e   mem_resp_i,

    output logic                      mtip_o
);

    logic               up_valid;
    logic               up_ready;
    logic [63:0]        up_rdata;
    mem_pkg::mem_resp_e up_resp;
    logic [63:0]        up_addr;
    logic [63:0]        up_wdata;
    mem_pkg::mem_size_e up_size;
    logic               up_write;
    logic [63:0]        raw_rdata;

    logic               clint_valid;
    logic               clint_ready;
    logic [63:0]        clint_rdata;
    logic [63:0]        clint_wdata;
    logic [63:0]        clint_addr;
    mem_pkg::mem_size_e clint_size;
    logic               clint_write;
    mem_pkg::mem_resp_e clint_resp;

    mem_access_fsm fsm0 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .mem_read_i   (mem_read_i),
        .mem_write_i  (mem_write_i),
        .bus_ready_i  (up_ready),
        .bus_rdata_i  (up_rdata),
        .bus_resp_i   (up_resp),
        .bus_valid_o  (up_valid),
        .raw_rdata_o  (raw_rdata),
        .access_ok_o  (access_ok_o),
        .access_err_o (access_err_o)
    );

    lsu_align align0 (
        .mem_read_i   (mem_read_i),
        .mem_write_i  (mem_write_i),
        .load_type_i  (load_type_i),
        .store_type_i (store_type_i),
        .ex_result_i  (ex_result_i),
        .wdata_i      (wdata_i),
        .raw_rdata_i  (raw_rdata),
        .bus_addr_o   (up_addr),
        .bus_wdata_o  (up_wdata),
        .bus_size_o   (up_size),
        .bus_write_o  (up_write),
        .rd_data_o    (rd_data_o)
    );

    bus_router #(
        .CLINT_BASE (CLINT_BASE)
    ) router0 (
        .up_valid_i    (up_valid),
        .up_addr_i     (up_addr),
        .up_wdata_i    (up_wdata),
        .up_size_i     (up_size),
        .up_write_i    (up_write),
        .up_ready_o    (up_ready),
        .up_rdata_o    (up_rdata),
        .up_resp_o     (up_resp),
        .mem_valid_o   (mem_valid_o),
        .mem_ready_i   (mem_ready_i),
        .mem_rdata_i   (mem_rdata_i),
        .mem_wdata_o   (mem_wdata_o),
        .mem_addr_o    (mem_addr_o),
        .mem_size_o    (mem_size_o),
        .mem_write_o   (mem_write_o),
        .mem_resp_i    (mem_resp_i),
        .clint_valid_o (clint_valid),
        .clint_ready_i (clint_ready),
        .clint_rdata_i (clint_rdata),
        .clint_wdata_o (clint_wdata),
        .clint_addr_o  (clint_addr),
        .clint_size_o  (clint_size),
        .clint_write_o (clint_write),
        .clint_resp_i  (clint_resp)
    );

    clint_timer #(
        .CLINT_BASE (CLINT_BASE),
        .TICK_DIV   (TICK_DIV)
    ) clint0 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (clint_valid),
        .addr_i  (clint_addr),
        .wdata_i (clint_wdata),
        .size_i  (clint_size),
        .write_i (clint_write),
        .ready_o (clint_ready),
        .rdata_o (clint_rdata),
        .resp_o  (clint_resp),
        .mtip_o  (mtip_o)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_mem_stage -f compile.f \
    --Mdir obj_dir -o sim_mem_stage

out="$(./obj_dir/sim_mem_stage)"
echo "$out"

if echo "$out" | grep -q "^No errors$"; then
    exit 0
fi
exit 1

// ==== tests/tb_mem_stage.sv ====
`default_nettype none

module tb_mem_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [63:0] CLINT_BASE = 64'h0200_0000;
    localparam logic [63:0] MEM_BASE   = 64'h8000_0000;
    localparam logic [63:0] MEM_LAST   = 64'h8000_0FFF;
    localparam logic [63:0] CMP_ADDR   = CLINT_BASE + 64'h4000;
    localparam logic [63:0] MTIME_ADDR = CLINT_BASE + 64'hBFF8;
    localparam int          TIMEOUT    = 100;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 inst_valid;
    logic                 mem_read;
    logic                 mem_write;
    mem_pkg::load_type_e  load_type;
    mem_pkg::store_type_e store_type;
    logic [63:0]          ex_result;
    logic [63:0]          wdata;
    logic                 access_ok;
    logic                 access_err;
    logic [63:0]          rd_data;
    logic                 mem_valid;
    logic                 mem_ready;
    logic [63:0]          mem_rdata;
    logic [63:0]          mem_wdata;
    logic [63:0]          mem_addr;
    mem_pkg::mem_size_e   mem_size;
    logic                 bus_write;
    mem_pkg::mem_resp_e   mem_resp;
    logic                 mtip;

    logic [63:0]          mem [0:511];
    logic [63:0]          shadow [0:511];
    logic [31:0]          lfsr = 32'hee49_82b0;
    int                   errors = 0;
    int                   timeouts = 0;
    int                   hold_total = 0;

    // results of the last access.
    logic [63:0]          last_rd;
    mem_pkg::mem_resp_e   last_resp;
    logic                 last_mtip;
    int                   last_cycles;
    int                   last_pulses;
    int                   last_valids;

    always #2 clk = ~clk;

    mem_stage #(
        .CLINT_BASE (CLINT_BASE),
        .TICK_DIV   (4)
    ) dut0 (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .inst_valid_i (inst_valid),
        .mem_read_i   (mem_read),
        .mem_write_i  (mem_write),
        .load_type_i  (load_type),
        .store_type_i (store_type),
        .ex_result_i  (ex_result),
        .wdata_i      (wdata),
        .access_ok_o  (access_ok),
        .access_err_o (access_err),
        .rd_data_o    (rd_data),
        .mem_valid_o  (mem_valid),
        .mem_ready_i  (mem_ready),
        .mem_rdata_i  (mem_rdata),
        .mem_wdata_o  (mem_wdata),
        .mem_addr_o   (mem_addr),
        .mem_size_o   (mem_size),
        .mem_write_o  (bus_write),
        .mem_resp_i   (mem_resp),
        .mtip_o       (mtip)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    // one lfsr step per bit taken.
    function logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    function automatic logic [63:0] fill_value(input int i);
        logic [63:0] addr;
        addr = MEM_BASE + 64'(i) * 64'd8;
        return {addr[31:0] ^ 32'h5a5a_c3c3, ~addr[31:0] ^ addr[63:32]};
    endfunction

    function automatic int load_bytes(input mem_pkg::load_type_e lt);
        case (lt)
            mem_pkg::LB, mem_pkg::LBU: return 1;
            mem_pkg::LH, mem_pkg::LHU: return 2;
            mem_pkg::LW, mem_pkg::LWU: return 4;
            default:                   return 8;
        endcase
    endfunction

    function automatic logic [63:0] ref_load(input logic [63:0] dw, input logic [2:0] off,
                                             input mem_pkg::load_type_e lt);
        logic [63:0] v;
        v = dw >> (8 * int'(off));
        case (lt)
            mem_pkg::LB:  return {{56{v[7]}}, v[7:0]};
            mem_pkg::LH:  return {{48{v[15]}}, v[15:0]};
            mem_pkg::LW:  return {{32{v[31]}}, v[31:0]};
            mem_pkg::LBU: return {56'd0, v[7:0]};
            mem_pkg::LHU: return {48'd0, v[15:0]};
            mem_pkg::LWU: return {32'd0, v[31:0]};
            default:      return v;
        endcase
    endfunction

    task automatic check_data(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input mem_pkg::mem_resp_e exp,
                              input mem_pkg::mem_resp_e act);
        if (act !== exp) begin
            $display("ERR %s: expected %s, actual %s", name, exp.name(), act.name());
            errors++;
        end
    endtask

    task automatic check_size(input string name, input mem_pkg::mem_size_e exp,
                              input mem_pkg::mem_size_e act);
        if (act !== exp) begin
            $display("ERR %s: expected %s, actual %s", name, exp.name(), act.name());
            errors++;
        end
    endtask

    // holds the instruction until access_ok, watching the bus meanwhile.
    task automatic do_access(input logic rd, input logic wr, input mem_pkg::load_type_e lt,
                             input mem_pkg::store_type_e st, input logic [63:0] addr,
                             input logic [63:0] data);
        logic               waiting;
        logic [63:0]        held_addr;
        logic [63:0]        held_wdata;
        mem_pkg::mem_size_e held_size;
        logic               held_write;
        @(posedge clk);
        #0.5;
        inst_valid  = 1'b1;
        mem_read    = rd;
        mem_write   = wr;
        load_type   = lt;
        store_type  = st;
        ex_result   = addr;
        wdata       = data;
        last_cycles = 0;
        last_pulses = 0;
        last_valids = 0;
        waiting     = 1'b0;
        @(negedge clk);
        while (!access_ok && last_cycles < TIMEOUT) begin
            if (waiting) begin
                check_data("addr held", held_addr, mem_addr);
                check_data("wdata held", held_wdata, mem_wdata);
                check_size("size held", held_size, mem_size);
                check_bit("write held", held_write, bus_write);
                hold_total++;
            end
            if (mem_valid) begin
                last_valids++;
            end
            if (mem_valid && mem_ready) begin
                last_pulses++;
            end
            waiting    = mem_valid && !mem_ready;
            held_addr  = mem_addr;
            held_wdata = mem_wdata;
            held_size  = mem_size;
            held_write = bus_write;
            @(negedge clk);
            last_cycles++;
        end
        if (mem_valid) begin
            last_valids++; // completion cycle too.
        end
        if (!access_ok) begin
            $display("timeout: no access_ok for address %h", addr);
            timeouts++;
        end
        last_rd   = rd_data;
        last_resp = access_err ? mem_pkg::ERR : mem_pkg::OKAY;
        last_mtip = mtip;
        @(posedge clk);
        #0.5;
        inst_valid = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        @(negedge clk);
    endtask

    task automatic issue_store(input mem_pkg::store_type_e st, input logic [63:0] addr,
                               input logic [63:0] data);
        do_access(1'b0, 1'b1, mem_pkg::LD, st, addr, data);
    endtask

    task automatic issue_load(input mem_pkg::load_type_e lt, input logic [63:0] addr);
        do_access(1'b1, 1'b0, lt, mem_pkg::SD, addr, 64'd0);
    endtask

    task automatic shadow_store(input logic [63:0] addr, input int nb, input logic [63:0] data);
        logic [63:0] word;
        int          off;
        word = shadow[addr[11:3]];
        off  = int'(addr[2:0]);
        for (int k = 0; k < nb; k++) begin
            word[8*(off+k) +: 8] = data[8*k +: 8];
        end
        shadow[addr[11:3]] = word;
    endtask

    // memory with 0..3 cycles of wait before the ready pulse.
    initial begin : mem_model
        logic [31:0] delay;
        logic [63:0] rel;
        logic [63:0] word;
        int          nbytes;
        int          off;
        mem_ready = 1'b0;
        mem_rdata = '0;
        mem_resp  = mem_pkg::OKAY;
        for (int i = 0; i < 512; i++) begin
            mem[i] = fill_value(i);
        end
        forever begin
            @(posedge clk);
            #0.5;
            mem_ready = 1'b0;
            if (mem_valid) begin
                delay = rand_bits(2);
                if (delay != 0) begin
                    repeat (delay) @(posedge clk);
                    #0.5;
                end
                if (mem_addr < MEM_BASE || mem_addr > MEM_LAST) begin
                    mem_resp  = mem_pkg::ERR;
                    mem_rdata = '0;
                end else begin
                    rel    = mem_addr - MEM_BASE;
                    word   = mem[rel[11:3]];
                    nbytes = 1 << int'(mem_size);
                    off    = int'(ex_result[2:0]); // bus address is dword aligned.
                    if (bus_write) begin
                        for (int b = 0; b < 8; b++) begin
                            if (b >= off && b < off + nbytes) begin
                                word[8*b +: 8] = mem_wdata[8*b +: 8];
                            end
                        end
                        mem[rel[11:3]] = word;
                    end
                    mem_resp  = mem_pkg::OKAY;
                    mem_rdata = word;
                end
                mem_ready = 1'b1;
            end
        end
    end

    initial begin : main
        logic [31:0]          r;
        logic [63:0]          addr;
        logic [63:0]          data;
        logic [63:0]          t0;
        logic [63:0]          t1;
        logic [2:0]           off;
        int                   nb;
        int                   wait_cycles;
        mem_pkg::store_type_e st;
        mem_pkg::load_type_e  lt;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        load_type  = mem_pkg::LD;
        store_type = mem_pkg::SD;
        ex_result  = '0;
        wdata      = '0;
        for (int i = 0; i < 512; i++) begin
            shadow[i] = fill_value(i);
        end
        repeat (3) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("reset mem_valid", 1'b0, mem_valid);
        check_bit("reset access_ok", 1'b0, access_ok);
        check_bit("reset access_err", 1'b0, access_err);
        check_bit("reset mtip", 1'b0, mtip);

        // random stores into a 16-doubleword window.
        for (int n = 0; n < 32; n++) begin
            r    = rand_bits(2);
            st   = mem_pkg::store_type_e'(r[1:0]);
            nb   = 1 << r[1:0];
            r    = rand_bits(7);
            off  = r[2:0] & ~3'(nb - 1);
            addr = MEM_BASE + {57'd0, r[6:3], off};
            data = {rand_bits(32), rand_bits(32)};
            issue_store(st, addr, data);
            check_resp($sformatf("%s @%h", st.name(), addr), mem_pkg::OKAY, last_resp);
            check_bit("store ready pulse", 1'b1, last_pulses == 1);
            shadow_store(addr, nb, data);
        end
        for (int dw = 0; dw < 16; dw++) begin
            for (int t = 0; t < 7; t++) begin
                lt   = mem_pkg::load_type_e'(3'(t));
                nb   = load_bytes(lt);
                r    = rand_bits(3);
                off  = r[2:0] & ~3'(nb - 1);
                addr = MEM_BASE + {57'd0, 4'(dw), off};
                issue_load(lt, addr);
                check_data($sformatf("%s @%h", lt.name(), addr),
                           ref_load(shadow[addr[11:3]], off, lt), last_rd);
                check_bit("load ready pulse", 1'b1, last_pulses == 1);
            end
        end

        // alu result passes straight through.
        for (int n = 0; n < 4; n++) begin
            data = {rand_bits(32), rand_bits(32)};
            do_access(1'b0, 1'b0, mem_pkg::LD, mem_pkg::SD, data, 64'd0);
            check_bit("alu same cycle", 1'b1, last_cycles == 0);
            check_data("alu result", data, last_rd);
            check_bit("alu bus idle", 1'b0, last_valids != 0);
        end

        issue_load(mem_pkg::LD, 64'h8000_1000);
        check_resp("load out of range", mem_pkg::ERR, last_resp);
        issue_store(mem_pkg::SW, 64'h8000_2004, 64'h1111_2222);
        check_resp("store out of range", mem_pkg::ERR, last_resp);

        issue_store(mem_pkg::SD, CMP_ADDR, 64'h0123_4567_89ab_cdef);
        check_resp("mtimecmp store", mem_pkg::OKAY, last_resp);
        check_bit("timer store bus idle", 1'b0, last_valids != 0);
        issue_load(mem_pkg::LD, CMP_ADDR);
        check_data("mtimecmp readback", 64'h0123_4567_89ab_cdef, last_rd);
        check_bit("timer load bus idle", 1'b0, last_valids != 0);
        issue_load(mem_pkg::LD, MTIME_ADDR);
        t0 = last_rd;
        issue_load(mem_pkg::LD, MTIME_ADDR);
        t1 = last_rd;
        check_bit("mtime not decreasing", 1'b1, t1 >= t0);
        issue_load(mem_pkg::LW, CMP_ADDR);
        check_resp("word timer load", mem_pkg::ERR, last_resp);
        issue_store(mem_pkg::SW, CMP_ADDR, 64'd0);
        check_resp("word timer store", mem_pkg::ERR, last_resp);
        issue_load(mem_pkg::LD, CMP_ADDR);
        check_data("mtimecmp after bad store", 64'h0123_4567_89ab_cdef, last_rd);

        // timer interrupt a few ticks ahead.
        issue_load(mem_pkg::LD, MTIME_ADDR);
        issue_store(mem_pkg::SD, CMP_ADDR, last_rd + 64'd8);
        wait_cycles = 0;
        while (!mtip && wait_cycles < TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!mtip) begin
            $display("timeout: mtip_o did not rise after mtimecmp was set");
            timeouts++;
        end
        issue_store(mem_pkg::SD, CMP_ADDR, '1);
        check_bit("mtip cleared", 1'b0, last_mtip);

        check_bit("ready wait seen", 1'b1, hold_total > 0);
        $display("check errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
